// File: include/alu_settings.svh
// Width constants, control word layout and APB register offsets for the ALU
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// Datapath widths
`define ALU_DATA_W 16 // Operand and result width
`define ALU_CCR_W 5 // Flags X N Z V C

// APB address width covers offsets up to 0x10
`define ALU_APB_ADDR_W 5

// Control word layout
`define ALU_CTRL_OP_W 5 // Opcode field in bits 4:0
`define ALU_CTRL_BYTE_BIT 8 // Set for byte size

// Register offsets
`define ALU_REG_OPA 5'h00 // Operand A is source and shift operand
`define ALU_REG_OPD 5'h04 // Operand D is the destination
`define ALU_REG_CTRL 5'h08 // Writing starts one operation
`define ALU_REG_RESULT 5'h0C // Read only
`define ALU_REG_CCR 5'h10 // Flags in bits 4:0

`endif

// File: source/aluPkg.sv
// Opcode enum, flag struct and opcode range check for the ALU
package aluPkg;

	// Codes as written into CTRL bits 4:0
	typedef enum logic [4:0] {
		opAnd = 5'd1,
		opAdd = 5'd2,
		opSub = 5'd3, // D minus A
		opAddx = 5'd4, // X as carry in
		opSubx = 5'd5,
		opNeg = 5'd6, // 0 minus A
		opNot = 5'd7, // 0 minus A minus 1
		opOr = 5'd8,
		opEor = 5'd9,
		opExt = 5'd10, // Byte to word
		opAsl = 5'd11,
		opAsr = 5'd12,
		opLsl = 5'd13,
		opLsr = 5'd14,
		opRol = 5'd15,
		opRor = 5'd16,
		opRoxl = 5'd17, // Rotate through X
		opRoxr = 5'd18
	} aluOpE;

	// Field order gives X in bit 4 and C in bit 0
	typedef struct packed {
		logic x; // Extend
		logic n; // Negative
		logic z; // Zero
		logic v; // Overflow
		logic c; // Carry or borrow
	} ccrT;

	// Codes 1 to 18 are defined
	function automatic logic opValid(input logic [4:0] code);
		return (code >= opAnd) && (code <= opRoxr);
	endfunction

endpackage

// File: source/aluIf.sv
// Command interface and result interface with their source and sink modports
`timescale 1ns/1ps
`include "alu_settings.svh"

// Register block to execute stage
interface aluCmdIf;
	import aluPkg::*;

	logic valid; // One cycle start pulse
	logic [`ALU_DATA_W-1:0] opA; // Source and shift operand
	logic [`ALU_DATA_W-1:0] opD; // Destination operand
	aluOpE op;
	logic isByte;

	modport source(output valid, opA, opD, op, isByte);
	modport sink(input valid, opA, opD, op, isByte);
endinterface

// Execute stage to flag logic and result capture
interface aluResIf;
	import aluPkg::*;

	logic valid; // One cycle per operation
	logic [`ALU_DATA_W-1:0] result;
	aluOpE op; // Selects flag mask
	ccrT flags; // Raw flags before masking

	modport source(output valid, result, op, flags);
	modport sink(input valid, result, op, flags);
endinterface

// File: source/aluShifter.sv
// One-bit shifter for shifts and rotates with carry-in placed by operand size
`timescale 1ns/1ps
`include "alu_settings.svh"

module aluShifter (
	input logic [`ALU_DATA_W-1:0] data,
	input logic isByte,
	input logic right,
	input logic cin, // Fill bit
	output logic [`ALU_DATA_W-1:0] result,
	output logic shiftOut, // Bit pushed out
	output logic msbChanged // Sign of active size flipped
);
	logic msbIn; // Sign bit before shift
	logic msbOut; // Sign bit after shift

	always_comb begin
		if (right) begin
			if (isByte)
				result = {data[`ALU_DATA_W-1:8], cin, data[7:1]}; // Upper byte kept
			else
				result = {cin, data[`ALU_DATA_W-1:1]};
		end else begin
			if (isByte)
				result = {data[`ALU_DATA_W-1:8], data[6:0], cin};
			else
				result = {data[`ALU_DATA_W-2:0], cin};
		end
	end

	assign msbIn = isByte ? data[7] : data[`ALU_DATA_W-1];
	assign msbOut = isByte ? result[7] : result[`ALU_DATA_W-1];

	// Left shifts lose the sign bit and right shifts lose bit 0
	assign shiftOut = right ? data[0] : msbIn;
	assign msbChanged = msbIn ^ msbOut; // ASL overflow

endmodule

// File: source/aluApbRegs.sv
// APB slave with operand, control and result registers, read mux and error response
`timescale 1ns/1ps
`include "alu_settings.svh"

module aluApbRegs (
	input logic clk,
	input logic arstN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`ALU_APB_ADDR_W-1:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	aluCmdIf.source cmd,
	aluResIf.sink res,
	input aluPkg::ccrT ccr,
	output logic ccrWrite,
	output aluPkg::ccrT ccrWdata
);
	import aluPkg::*;

	logic access; // ACCESS cycle, completes at this edge
	logic wrAccess;
	logic addrHit; // One of the five offsets
	logic opBad; // CTRL write with unknown opcode
	logic errAccess;
	logic ctrlWrite; // Accepted start
	logic [`ALU_DATA_W-1:0] opAQ;
	logic [`ALU_DATA_W-1:0] opDQ;
	logic [`ALU_CTRL_OP_W-1:0] opQ;
	logic isByteQ;
	logic cmdValidQ;
	logic [`ALU_DATA_W-1:0] resultQ;
	logic [31:0] rdata;

	assign pready = 1'b1; // No wait states
	assign access = psel && penable;
	assign wrAccess = access && pwrite;

	// Address decode
	always_comb begin
		case (paddr)
			`ALU_REG_OPA,
			`ALU_REG_OPD,
			`ALU_REG_CTRL,
			`ALU_REG_RESULT,
			`ALU_REG_CCR: addrHit = 1'b1;
			default: addrHit = 1'b0;
		endcase
	end

	assign opBad = pwrite && (paddr == `ALU_REG_CTRL) &&
		!opValid(pwdata[`ALU_CTRL_OP_W-1:0]);
	assign errAccess = access && (!addrHit || opBad);
	assign pslverr = errAccess; // Only during ACCESS
	assign ctrlWrite = wrAccess && (paddr == `ALU_REG_CTRL) && !opBad;

	// Host flag write lands at its own ACCESS edge
	assign ccrWrite = wrAccess && (paddr == `ALU_REG_CCR);
	assign ccrWdata = pwdata[`ALU_CCR_W-1:0];

	// Operand and control registers
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			opAQ <= '0;
			opDQ <= '0;
			opQ <= '0;
			isByteQ <= 1'b0;
		end else if (wrAccess && !errAccess) begin
			case (paddr)
				`ALU_REG_OPA: opAQ <= pwdata[`ALU_DATA_W-1:0];
				`ALU_REG_OPD: opDQ <= pwdata[`ALU_DATA_W-1:0];
				`ALU_REG_CTRL: begin
					opQ <= pwdata[`ALU_CTRL_OP_W-1:0];
					isByteQ <= pwdata[`ALU_CTRL_BYTE_BIT];
				end
				default: ; // RESULT is read only and CCR goes to the flag block
			endcase
		end
	end

	// Start pulse and result capture
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			cmdValidQ <= 1'b0;
			resultQ <= '0;
		end else begin
			cmdValidQ <= ctrlWrite; // High for the cycle after the write
			if (res.valid)
				resultQ <= res.result;
		end
	end

	assign cmd.valid = cmdValidQ;
	assign cmd.opA = opAQ;
	assign cmd.opD = opDQ;
	assign cmd.op = aluOpE'(opQ); // Range checked on write
	assign cmd.isByte = isByteQ;

	// Read mux, zero extended
	always_comb begin
		rdata = '0;
		case (paddr)
			`ALU_REG_OPA: rdata[`ALU_DATA_W-1:0] = opAQ;
			`ALU_REG_OPD: rdata[`ALU_DATA_W-1:0] = opDQ;
			`ALU_REG_CTRL: begin
				rdata[`ALU_CTRL_OP_W-1:0] = opQ;
				rdata[`ALU_CTRL_BYTE_BIT] = isByteQ;
			end
			`ALU_REG_RESULT: rdata[`ALU_DATA_W-1:0] = resultQ;
			`ALU_REG_CCR: rdata[`ALU_CCR_W-1:0] = ccr;
			default: ; // Unmapped reads return zero with an error
		endcase
	end

	assign prdata = (access && !pwrite) ? rdata : '0; // Zero outside read ACCESS

	// SETUP always moves on to ACCESS with select held
	apbSetupToAccess: assert property (@(posedge clk) disable iff (!arstN)
		(psel && !penable) |=> (psel && penable));

	// Enable never seen without select
	apbEnableNeedsSel: assert property (@(posedge clk) disable iff (!arstN)
		penable |-> psel);

endmodule

// File: source/aluExecute.sv
// Execute stage with adder, logic ops, EXT, shifter control, raw flags and result register
`timescale 1ns/1ps
`include "alu_settings.svh"

module aluExecute (
	input logic clk,
	input logic arstN,
	aluCmdIf.sink cmd,
	aluResIf.source res,
	input logic xFlag // Current X from the flag register
);
	import aluPkg::*;

	logic isAdd; // Add, otherwise subtract
	logic addCin;
	logic [`ALU_DATA_W-1:0] addD; // Zero for NEG and NOT
	logic [`ALU_DATA_W:0] sumWord;
	logic [8:0] sumByte;
	logic [`ALU_DATA_W-1:0] sum;
	logic addCout; // Carry or borrow of active size
	logic signA;
	logic signD;
	logic signR;
	logic srcSign; // A sign seen by the adder
	logic addOv;
	logic shRight;
	logic shCin;
	logic shMsb; // Sign bit of A at active size
	logic [`ALU_DATA_W-1:0] shResult;
	logic shOut;
	logic shMsbChanged;
	logic [`ALU_DATA_W-1:0] result;
	ccrT flags;

	// Adder controls
	assign isAdd = (cmd.op == opAdd) || (cmd.op == opAddx);
	assign addD = ((cmd.op == opNeg) || (cmd.op == opNot)) ? '0 : cmd.opD;

	always_comb begin
		case (cmd.op)
			opAddx, opSubx: addCin = xFlag;
			opNot: addCin = 1'b1; // 0 - A - 1
			default: addCin = 1'b0;
		endcase
	end

	// Both sizes computed with carry bit on top
	assign sumWord = isAdd ?
		{1'b0, addD} + {1'b0, cmd.opA} + {{`ALU_DATA_W{1'b0}}, addCin} :
		{1'b0, addD} - {1'b0, cmd.opA} - {{`ALU_DATA_W{1'b0}}, addCin};
	assign sumByte = isAdd ?
		{1'b0, addD[7:0]} + {1'b0, cmd.opA[7:0]} + {8'b0, addCin} :
		{1'b0, addD[7:0]} - {1'b0, cmd.opA[7:0]} - {8'b0, addCin};

	assign sum = cmd.isByte ? {addD[`ALU_DATA_W-1:8], sumByte[7:0]} : sumWord[`ALU_DATA_W-1:0];
	assign addCout = cmd.isByte ? sumByte[8] : sumWord[`ALU_DATA_W];

	// Signed overflow of active size
	assign signA = cmd.isByte ? cmd.opA[7] : cmd.opA[`ALU_DATA_W-1];
	assign signD = cmd.isByte ? addD[7] : addD[`ALU_DATA_W-1];
	assign signR = cmd.isByte ? sumByte[7] : sumWord[`ALU_DATA_W-1];
	assign srcSign = isAdd ? signA : ~signA; // Subtract adds the inverse
	assign addOv = (srcSign & signD & ~signR) | (~srcSign & ~signD & signR);

	// Shift direction and fill bit
	assign shRight = cmd.op inside {opAsr, opLsr, opRor, opRoxr};
	assign shMsb = signA;

	always_comb begin
		case (cmd.op)
			opAsr, opRol: shCin = shMsb; // Sign repeat or wrap
			opRor: shCin = cmd.opA[0];
			opRoxl, opRoxr: shCin = xFlag; // Through X
			default: shCin = 1'b0; // Logical and ASL fill
		endcase
	end

	aluShifter uShifter (
		.data(cmd.opA),
		.isByte(cmd.isByte),
		.right(shRight),
		.cin(shCin),
		.result(shResult),
		.shiftOut(shOut),
		.msbChanged(shMsbChanged)
	);

	// Result select
	always_comb begin
		case (cmd.op)
			opAnd: result = cmd.opA & cmd.opD;
			opOr: result = cmd.opA | cmd.opD;
			opEor: result = cmd.opA ^ cmd.opD;
			opExt: result = {{(`ALU_DATA_W-8){cmd.opA[7]}}, cmd.opA[7:0]};
			opAsl, opAsr, opLsl, opLsr,
			opRol, opRor, opRoxl, opRoxr: result = shResult;
			default: result = sum; // Adder group
		endcase
	end

	// Raw flags, the mask decides what lands
	always_comb begin
		flags.x = xFlag;
		flags.n = cmd.isByte ? result[7] : result[`ALU_DATA_W-1];
		flags.z = cmd.isByte ? ~|result[7:0] : ~|result;
		flags.v = 1'b0; // Clear for logic, NOT and EXT
		flags.c = 1'b0;
		case (cmd.op)
			opAdd, opSub, opAddx, opSubx, opNeg: begin
				flags.c = addCout;
				flags.x = addCout;
				flags.v = addOv;
			end
			opAsl: begin
				flags.c = shOut;
				flags.x = shOut;
				flags.v = shMsbChanged;
			end
			opAsr, opLsl, opLsr, opRoxl, opRoxr: begin
				flags.c = shOut;
				flags.x = shOut;
			end
			opRol, opRor: flags.c = shOut; // X untouched
			default: ;
		endcase
	end

	// Result register, one res cycle per command
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			res.valid <= 1'b0;
			res.result <= '0;
			res.op <= opAnd; // Any legal code
			res.flags <= '0;
		end else begin
			res.valid <= cmd.valid;
			if (cmd.valid) begin
				res.result <= result;
				res.op <= cmd.op;
				res.flags <= flags;
			end
		end
	end

endmodule

// File: source/ccrUpdate.sv
// Flag register with per-opcode update masks, extended Z rule and host writes
`timescale 1ns/1ps

module ccrUpdate (
	input logic clk,
	input logic arstN,
	aluResIf.sink res,
	input logic ccrWrite, // Host write strobe
	input aluPkg::ccrT ccrWdata,
	output aluPkg::ccrT ccr,
	output logic xFlag
);
	import aluPkg::*;

	ccrT ccrQ;
	ccrT mask; // Set bits take the raw flag
	ccrT nextCcr;

	// Update mask per opcode
	always_comb begin
		mask = '1; // Arithmetic, shifts and ROX touch all five
		case (res.op)
			opAnd, opOr, opEor,
			opNot, opExt,
			opRol, opRor: mask.x = 1'b0; // X kept
			default: ;
		endcase
	end

	// Merge raw flags into old ones
	always_comb begin
		nextCcr = (res.flags & mask) | (ccrQ & ~mask);
		if ((res.op == opAddx) || (res.op == opSubx))
			nextCcr.z = res.flags.z & ccrQ.z; // Multi-word ops only clear Z
	end

	// Flag register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			ccrQ <= '0;
		else if (res.valid)
			ccrQ <= nextCcr; // Operation wins
		else if (ccrWrite)
			ccrQ <= ccrWdata; // Direct host load
	end

	assign ccr = ccrQ;
	assign xFlag = ccrQ.x; // Carry in for ADDX SUBX ROXL ROXR

	// One result per command
	resValidPulse: assert property (@(posedge clk) disable iff (!arstN)
		res.valid |=> !res.valid);

	// Host writes never meet a result update
	ccrWriteNoClash: assert property (@(posedge clk) disable iff (!arstN)
		!(res.valid && ccrWrite));

endmodule

// File: source/aluTop.sv
// Top level with APB ports, interface instances, register block, execute stage and flag logic
`timescale 1ns/1ps
`include "alu_settings.svh"

module aluTop (
	input logic clk,
	input logic arstN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`ALU_APB_ADDR_W-1:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);
	import aluPkg::*;

	ccrT ccr; // Flag register for reads
	ccrT ccrWdata;
	logic ccrWrite;
	logic xFlag;

	aluCmdIf cmdIf ();
	aluResIf resIf ();

	// APB side
	aluApbRegs uApbRegs (
		.clk(clk),
		.arstN(arstN),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.cmd(cmdIf),
		.res(resIf),
		.ccr(ccr),
		.ccrWrite(ccrWrite),
		.ccrWdata(ccrWdata)
	);

	aluExecute uExecute (
		.clk(clk),
		.arstN(arstN),
		.cmd(cmdIf),
		.res(resIf),
		.xFlag(xFlag)
	);

	ccrUpdate uCcrUpdate (
		.clk(clk),
		.arstN(arstN),
		.res(resIf),
		.ccrWrite(ccrWrite),
		.ccrWdata(ccrWdata),
		.ccr(ccr),
		.xFlag(xFlag)
	);

endmodule

// File: verification/aluTb.sv
// Testbench for aluTop with APB tasks, LFSR stimulus, reference model and checking process
`timescale 1ns/1ps
`include "alu_settings.svh"

module aluTb;
	import aluPkg::*;

	logic clk;
	logic arstN;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`ALU_APB_ADDR_W-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic [15:0] lfsr; // Random source state

	// Pending checks filled by stimulus and drained by the checker
	string nameQ[$];
	logic [31:0] expQ[$];
	logic [31:0] actQ[$];
	logic [31:0] maskQ[$];

	localparam aluOpE logicOps [5] = '{opAnd, opOr, opEor, opNot, opExt};

	aluTop UUT (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "Simulation stopped on error");
	endtask

	// Taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic takeBits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr); // One step per bit
			v = {v[14:0], lfsr[0]};
		end
	endtask

	// Expected {X N Z V C, result} from the ALU rules
	function automatic logic [20:0] aluRef(input aluOpE op, input logic isByte,
		input logic [15:0] a, input logic [15:0] d, input logic [4:0] ccrIn);
		int w;
		logic [15:0] r;
		logic x;
		logic v;
		logic c;
		logic z;
		logic sub;
		longint ua;
		longint ud;
		longint sa;
		longint sd;
		longint cinV;
		longint full;
		longint ts;
		longint smax;
		w = isByte ? 8 : 16;
		smax = isByte ? 127 : 32767;
		ua = isByte ? {8'b0, a[7:0]} : a; // Unsigned at active size
		ud = isByte ? {8'b0, d[7:0]} : d;
		sa = isByte ? longint'($signed(a[7:0])) : longint'($signed(a));
		sd = isByte ? longint'($signed(d[7:0])) : longint'($signed(d));
		x = ccrIn[4];
		v = 1'b0;
		c = 1'b0;
		case (op)
			opAdd, opSub, opAddx, opSubx, opNeg: begin
				sub = (op != opAdd) && (op != opAddx); // D minus A
				cinV = ((op == opAddx) || (op == opSubx)) ? longint'(ccrIn[4]) : 0;
				if (op == opNeg) begin
					ud = 0;
					sd = 0;
				end
				full = sub ? ud - ua - cinV : ud + ua + cinV;
				ts = sub ? sd - sa - cinV : sd + sa + cinV; // True signed value
				r = full[15:0];
				c = sub ? (full < 0) : (full > 2 * smax + 1);
				v = (ts > smax) || (ts < -smax - 1);
				x = c;
			end
			opNot: r = 16'h0000 - a - 16'h0001;
			opAnd: r = a & d;
			opOr: r = a | d;
			opEor: r = a ^ d;
			opExt: r = {{8{a[7]}}, a[7:0]};
			opAsl, opLsl: begin
				r = a << 1;
				c = a[w-1];
				x = c;
				v = (op == opAsl) && (a[w-1] != r[w-1]); // Sign flipped
			end
			opAsr, opLsr: begin
				r = ua[15:0] >> 1;
				r[w-1] = (op == opAsr) ? a[w-1] : 1'b0;
				c = a[0];
				x = c;
			end
			opRol, opRoxl: begin
				r = a << 1;
				r[0] = (op == opRol) ? a[w-1] : ccrIn[4];
				c = a[w-1];
				x = (op == opRoxl) ? c : x; // ROL keeps X
			end
			default: begin // ROR and ROXR
				r = ua[15:0] >> 1;
				r[w-1] = (op == opRor) ? a[0] : ccrIn[4];
				c = a[0];
				x = (op == opRoxr) ? c : x;
			end
		endcase
		z = isByte ? (r[7:0] == 8'h00) : (r == 16'h0000);
		if ((op == opAddx) || (op == opSubx))
			z = z & ccrIn[2]; // Only ever cleared
		return {x, r[w-1], z, v, c, r};
	endfunction

	// One APB access returning read data and slave error
	task automatic apbTransfer(input logic wr, input logic [`ALU_APB_ADDR_W-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int cycles;
		@(posedge clk);
		psel <= 1'b1; // SETUP
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1; // ACCESS
		cycles = 0;
		@(negedge clk);
		while ((pready !== 1'b1) && (cycles < 16)) begin
			@(negedge clk);
			cycles++;
		end
		if (pready !== 1'b1) begin
			abortRun("APB access saw no PREADY within 16 cycles");
		end else begin
			rdata = prdata; // Stable mid cycle
			err = pslverr;
			@(posedge clk);
			psel <= 1'b0;
			penable <= 1'b0;
		end
	endtask

	task automatic writeReg(input logic [`ALU_APB_ADDR_W-1:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic err;
		apbTransfer(1'b1, addr, data, rdata, err);
		assert (err == 1'b0)
		else abortRun($sformatf("Unexpected slave error on write to offset %h", addr));
	endtask

	task automatic readReg(input logic [`ALU_APB_ADDR_W-1:0] addr, output logic [31:0] data);
		logic err;
		apbTransfer(1'b0, addr, 32'h0, data, err);
		assert (err == 1'b0)
		else abortRun($sformatf("Unexpected slave error on read from offset %h", addr));
	endtask

	task automatic queueCheck(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal, input logic [31:0] mask);
		nameQ.push_back(name);
		expQ.push_back(expVal);
		actQ.push_back(actVal);
		maskQ.push_back(mask);
	endtask

	// Load operands, start, read back result and flags
	task automatic runOp(input string tag, input aluOpE op, input logic isByte,
		input logic [15:0] a, input logic [15:0] d, input logic [4:0] ccrIn,
		input logic loadCcr, output logic [4:0] ccrOut);
		logic [20:0] expVal;
		logic [31:0] rd;
		string name;
		name = $sformatf("%s %s %s", tag, op.name(), isByte ? "byte" : "word");
		expVal = aluRef(op, isByte, a, d, ccrIn);
		writeReg(`ALU_REG_OPA, {16'b0, a});
		writeReg(`ALU_REG_OPD, {16'b0, d});
		if (loadCcr)
			writeReg(`ALU_REG_CCR, {27'b0, ccrIn});
		writeReg(`ALU_REG_CTRL, {23'b0, isByte, 3'b0, op}); // Starts the operation
		readReg(`ALU_REG_RESULT, rd);
		queueCheck({name, " result"}, {16'b0, expVal[15:0]}, rd, isByte ? 32'hFF : 32'hFFFF);
		readReg(`ALU_REG_CCR, rd);
		queueCheck({name, " ccr"}, {27'b0, expVal[20:16]}, rd, 32'hFFFF_FFFF);
		ccrOut = expVal[20:16];
	endtask

	// Checker drains the queue every clock
	initial begin
		string name;
		logic [31:0] expVal;
		logic [31:0] actVal;
		logic [31:0] mask;
		forever begin
			@(posedge clk);
			while (nameQ.size() > 0) begin
				name = nameQ.pop_front();
				expVal = expQ.pop_front();
				actVal = actQ.pop_front();
				mask = maskQ.pop_front();
				assert ((actVal & mask) == (expVal & mask))
				else abortRun($sformatf("Fail %s expected %h actual %h",
					name, expVal & mask, actVal & mask));
			end
		end
	end

	initial begin
		logic [15:0] a;
		logic [15:0] d;
		logic [15:0] bits;
		logic [4:0] ccrNow;
		logic [31:0] rd;
		logic [20:0] expHeld;
		logic [31:0] resultHeld;
		logic [31:0] ccrHeld;
		logic err;
		int cycles;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		arstN = 1'b0;
		lfsr = 16'd37106;
		repeat (8) @(posedge clk);
		arstN <= 1'b1;

		// Reset values
		readReg(`ALU_REG_CCR, rd);
		queueCheck("reset ccr", 32'h0, rd, 32'hFFFF_FFFF);
		readReg(`ALU_REG_RESULT, rd);
		queueCheck("reset result", 32'h0, rd, 32'hFFFF_FFFF);

		// ADD SUB ADDX SUBX NEG are codes 2 to 6
		for (int code = 2; code <= 6; code++)
			for (int sz = 0; sz < 2; sz++)
				for (int i = 0; i < 6; i++) begin
					takeBits(16, a);
					takeBits(16, d);
					takeBits(5, bits);
					runOp("arith", aluOpE'(code), sz[0], a, d, bits[4:0], 1'b1, ccrNow);
				end

		foreach (logicOps[k])
			for (int sz = 0; sz < 2; sz++)
				for (int i = 0; i < 4; i++) begin
					takeBits(16, a);
					takeBits(16, d);
					takeBits(5, bits);
					runOp("logic", logicOps[k], sz[0], a, d, bits[4:0], 1'b1, ccrNow);
				end

		// Shifts and rotates are codes 11 to 18 with X preset both ways
		for (int code = 11; code <= 18; code++)
			for (int xv = 0; xv < 2; xv++)
				for (int sz = 0; sz < 2; sz++)
					for (int i = 0; i < 3; i++) begin
						takeBits(16, a);
						takeBits(16, d);
						takeBits(4, bits);
						runOp("shift", aluOpE'(code), sz[0], a, d, {xv[0], bits[3:0]},
							1'b1, ccrNow);
					end

		// Extended Z chain carries flags over without rewriting
		takeBits(16, a);
		runOp("extZ", opSubx, 1'b0, a, a, 5'b00100, 1'b1, ccrNow);
		runOp("extZ", opAddx, 1'b0, 16'h0001, 16'h0002, ccrNow, 1'b0, ccrNow);
		runOp("extZ", opAddx, 1'b0, 16'h0000, 16'h0000, ccrNow, 1'b0, ccrNow);

		// Error responses leave state alone
		expHeld = aluRef(opAdd, 1'b0, 16'h1234, 16'h0F0F, ccrNow);
		runOp("held", opAdd, 1'b0, 16'h1234, 16'h0F0F, ccrNow, 1'b0, ccrNow);
		resultHeld = {16'b0, expHeld[15:0]}; // Nonzero so a stray start shows
		ccrHeld = {27'b0, expHeld[20:16]};
		apbTransfer(1'b1, 5'h14, 32'hFFFF_FFFF, rd, err); // Unmapped offset
		queueCheck("unmapped write pslverr", 32'h1, {31'b0, err}, 32'hFFFF_FFFF);
		apbTransfer(1'b1, `ALU_REG_CTRL, 32'h0000_0100, rd, err); // Opcode 0
		queueCheck("opcode 0 pslverr", 32'h1, {31'b0, err}, 32'hFFFF_FFFF);
		readReg(`ALU_REG_RESULT, rd);
		queueCheck("result after errors", resultHeld, rd, 32'hFFFF_FFFF);
		readReg(`ALU_REG_CCR, rd);
		queueCheck("ccr after errors", ccrHeld, rd, 32'hFFFF_FFFF);

		cycles = 0;
		while ((nameQ.size() != 0) && (cycles < 8)) begin
			@(posedge clk);
			cycles++;
		end
		if (nameQ.size() == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			abortRun("Checker left entries unchecked at end of run");
		end
	end

endmodule

// File: filelist.f
+incdir+include
source/aluPkg.sv
source/aluIf.sv
source/aluShifter.sv
source/aluApbRegs.sv
source/aluExecute.sv
source/ccrUpdate.sv
source/aluTop.sv
verification/aluTb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module aluTb -f filelist.f -o simAlu || exit 1
out="$(./obj_dir/simAlu 2>&1)"
echo "$out"
echo "$out" | grep -qF "** PASS **" && echo "Run passed" || { echo "Run failed"; exit 1; }
